// File: m6502_core.f
+incdir+dv
common/m6502_pkg.sv
decode/m6502_decode.sv
source/m6502_alu.sv
source/m6502_regfile.sv
source/m6502_sequencer.sv
source/m6502_core.sv
dv/tb_m6502.sv

// File: dv/tb_m6502_model.svh
/*
 * instruction-level reference for the kept 6502 subset
 * runs the program image and collects the expected store stream
 */
`ifndef TB_M6502_MODEL_SVH
`define TB_M6502_MODEL_SVH

function automatic flags_t set_nz(input flags_t f, input data_t r);
   flags_t o;
   o   = f;
   o.n = r[7];
   o.z = (r == 8'h00);
   return o;
endfunction

function automatic void record_store(input addr_t ad, input data_t d);
   ref_mem[ad] = d;
   model_addr.push_back(ad);
   model_data.push_back(d);
endfunction

// runs until a jmp to its own address and returns that address
function automatic addr_t run_model();
   addr_t      pc;
   addr_t      ea;
   data_t      a;
   data_t      x;
   data_t      y;
   data_t      op;
   data_t      m;
   data_t      b;
   logic [8:0] s;
   logic       t;
   flags_t     f;
   int         len;
   ref_mem = image;
   model_addr.delete();
   model_data.delete();
   pc = {ref_mem[16'hFFFD], ref_mem[16'hFFFC]};
   a  = 8'h00;
   x  = 8'h00;
   y  = 8'h00;
   f  = '0;
   repeat (50000) begin
      op  = ref_mem[pc];
      ea  = {8'h00, ref_mem[pc + 16'd1]};
      m   = ea[7:0];   // immediate or branch offset
      len = 1;
      if (op inside {8'h09, 8'h29, 8'h49, 8'h69, 8'hA9, 8'hC9, 8'hE9,
                     8'hA2, 8'hA0, 8'hC0, 8'hE0}) begin
         len = 2;
      end else if (op inside {8'h05, 8'h25, 8'h45, 8'h65, 8'h85, 8'hA5,
                              8'hC5, 8'hE5, 8'h86, 8'hA6, 8'h84, 8'hA4}) begin
         len = 2;
         m   = ref_mem[ea];
      end else if (op inside {8'h0D, 8'h2D, 8'h4D, 8'h6D, 8'h8D, 8'hAD, 8'hCD,
                              8'hED, 8'h8E, 8'hAE, 8'h8C, 8'hAC, 8'h4C}) begin
         len = 3;
         ea  = {ref_mem[pc + 16'd2], m};
         m   = ref_mem[ea];
      end else if (op[4:0] == 5'b10000) begin
         len = 2;
      end
      case (op)
         8'hA9, 8'hA5, 8'hAD: a = m;
         8'hA2, 8'hA6, 8'hAE: x = m;
         8'hA0, 8'hA4, 8'hAC: y = m;
         8'h85, 8'h8D:        record_store(ea, a);
         8'h86, 8'h8E:        record_store(ea, x);
         8'h84, 8'h8C:        record_store(ea, y);
         8'h09, 8'h05, 8'h0D: a = a | m;
         8'h29, 8'h25, 8'h2D: a = a & m;
         8'h49, 8'h45, 8'h4D: a = a ^ m;
         8'h69, 8'h65, 8'h6D, 8'hE9, 8'hE5, 8'hED: begin
            b   = op[7] ? ~m : m;   // sbc adds the complement
            s   = {1'b0, a} + {1'b0, b} + {8'h00, f.c};
            f.v = (a[7] == b[7]) && (s[7] != a[7]);
            f.c = s[8];
            a   = s[7:0];
            f   = set_nz(f, a);
         end
         8'hC9, 8'hC5, 8'hCD, 8'hE0, 8'hC0: begin
            b   = (op == 8'hE0) ? x : (op == 8'hC0) ? y : a;
            f.c = (b >= m);
            f   = set_nz(f, b - m);
         end
         8'hAA: x = a;
         8'hA8: y = a;
         8'h8A: a = x;
         8'h98: a = y;
         8'hE8: x = x + 8'd1;
         8'hC8: y = y + 8'd1;
         8'hCA: x = x - 8'd1;
         8'h88: y = y - 8'd1;
         8'h18: f.c = 1'b0;
         8'h38: f.c = 1'b1;
         8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0: begin
            case (op[7:6])
               2'b00:   t = f.n;
               2'b01:   t = f.v;
               2'b10:   t = f.c;
               default: t = f.z;
            endcase
            if (t == op[5]) pc = pc + {{8{m[7]}}, m};
         end
         8'h4C: begin
            if (ea == pc) return pc;
            pc  = ea;
            len = 0;
         end
         default: ;   // everything else is a one byte nop
      endcase
      if (op inside {8'hA9, 8'hA5, 8'hAD, 8'h09, 8'h05, 8'h0D, 8'h29, 8'h25,
                     8'h2D, 8'h49, 8'h45, 8'h4D, 8'h8A, 8'h98}) f = set_nz(f, a);
      if (op inside {8'hA2, 8'hA6, 8'hAE, 8'hAA, 8'hE8, 8'hCA}) f = set_nz(f, x);
      if (op inside {8'hA0, 8'hA4, 8'hAC, 8'hA8, 8'hC8, 8'h88}) f = set_nz(f, y);
      pc = pc + len[15:0];
   end
   run_model = pc;
   $display("the reference model never reached a jump to its own address");
   $display("SOME TESTS FAILED");
   $fatal(1, "reference model step limit");
endfunction

`endif

// File: dv/tb_m6502.sv
/*
 * m6502 core testbench
 * stalling byte memory, generated programs and store stream compare
 */
module tb_m6502 import m6502_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   logic     clk;
   logic     reset_n;
   logic     ready;
   data_t    rd_data;
   bus_req_t bus;
   data_t    mem     [0:65535];
   data_t    image   [0:65535];
   data_t    ref_mem [0:65535];
   addr_t    model_addr [$];
   data_t    model_data [$];
   addr_t    exp_addr [$];
   data_t    exp_data [$];
   addr_t    first_reads [$];
   addr_t    halt_addr;
   addr_t    wp;          // assembly pointer
   bus_req_t held_bus;
   logic     waiting;
   logic     in_reset;    // reset seen by at least one edge
   int       halt_reads;
   int       stall_pct;
   int       errors;
   integer   seed = 32'h737b;

   `include "tb_m6502_model.svh"

   m6502_core i_dut (
      .clk       (clk),
      .reset_n   (reset_n),
      .rd_data_i (rd_data),
      .ready_i   (ready),
      .bus_o     (bus)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   assign rd_data = mem[bus.addr];

   always @(posedge clk) begin
      if (ready && bus.wr) mem[bus.addr] <= bus.wr_data;
   end

   always @(posedge clk) begin
      ready <= ({$random(seed)} % 100) >= stall_pct;
   end

   task automatic abort_run();
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
      if (got !== expected) begin
         errors++;
         $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
         abort_run();
      end
   endtask

   function automatic data_t random_byte();
      return $random(seed);
   endfunction

   task automatic emit(input data_t op, input addr_t arg, input int len);
      image[wp] = op;
      if (len > 1) image[wp + 16'd1] = arg[7:0];
      if (len > 2) image[wp + 16'd2] = arg[15:8];
      wp = wp + len[15:0];
   endtask

   task automatic build_program();
      data_t      v;
      data_t      ld;
      data_t      cp;
      logic [2:0] aaa;
      logic [2:0] bbb;
      int         mode;
      for (int i = 0; i < 65536; i++) begin
         image[i] = i[7:0] ^ i[15:8] ^ 8'hA5;
      end
      image[16'hFFFC] = 8'h00;
      image[16'hFFFD] = 8'h08;
      wp = 16'h0800;
      emit(8'hA9, random_byte(), 2);
      emit(8'h85, 16'h0010, 2);
      emit(8'hA2, random_byte(), 2);
      emit(8'h8E, 16'h0300, 3);
      emit(8'hA0, random_byte(), 2);
      emit(8'h84, 16'h0011, 2);
      emit(8'hAD, {8'h03, random_byte()}, 3);
      emit(8'hA6, {8'h00, random_byte()}, 2);
      emit(8'hAC, {8'h03, random_byte()}, 3);
      emit(8'h8D, 16'h0301, 3);
      emit(8'h86, 16'h0012, 2);
      emit(8'h8C, 16'h0302, 3);
      emit(8'hA5, 16'h0011, 2);   // reads back an earlier store
      emit(8'hA4, 16'h0010, 2);
      emit(8'hAE, 16'h0300, 3);
      emit(8'h85, 16'h0013, 2);
      emit(8'h84, 16'h0014, 2);
      emit(8'h86, 16'h0015, 2);
      for (int k = 0; k < 12; k++) begin
         case (k % 6)
            4:       aaa = 3'b111;   // sbc
            5:       aaa = 3'b110;   // cmp
            default: aaa = 3'(k % 6);
         endcase
         mode = {$random(seed)} % 3;
         bbb  = (mode == 0) ? 3'b010 : (mode == 1) ? 3'b001 : 3'b011;
         emit(($random(seed) & 1) ? 8'h38 : 8'h18, 16'h0000, 1);
         emit(8'hA9, random_byte(), 2);
         emit({aaa, bbb, 2'b01}, {(mode == 2) ? 8'h03 : 8'h00, random_byte()}, (mode == 2) ? 3 : 2);
         emit(8'h85, 16'h0020 + k[15:0], 2);
      end
      emit(8'hAA, 16'h0000, 1);
      emit(8'hE8, 16'h0000, 1);
      emit(8'hA8, 16'h0000, 1);
      emit(8'h88, 16'h0000, 1);
      emit(8'h8A, 16'h0000, 1);
      emit(8'h85, 16'h002C, 2);
      emit(8'h98, 16'h0000, 1);
      emit(8'hC8, 16'h0000, 1);
      emit(8'h8C, 16'h0303, 3);
      emit(8'hCA, 16'h0000, 1);
      emit(8'h86, 16'h002D, 2);
      // flags from adc, cmp, cpx or cpy, then one of the eight branches
      for (int k = 0; k < 16; k++) begin
         v = random_byte();
         case (k % 4)
            0:       begin ld = 8'hA9; cp = 8'h69; end
            1:       begin ld = 8'hA9; cp = 8'hC9; end
            2:       begin ld = 8'hA2; cp = 8'hE0; end
            default: begin ld = 8'hA0; cp = 8'hC0; end
         endcase
         emit(($random(seed) & 1) ? 8'h38 : 8'h18, 16'h0000, 1);
         emit(ld, v, 2);
         emit(cp, (($random(seed) & 3) == 0) ? v : random_byte(), 2);
         emit({k[2:0], 5'b10000}, 16'h0004, 2);
         emit(8'hA0, 16'h004E, 2);   // not taken marker
         emit(8'h84, 16'h0030 + k[15:0], 2);
         emit(8'hA0, 16'h0054, 2);
         emit(8'h84, 16'h0060 + k[15:0], 2);
      end
      v = (random_byte() & 8'h0F) + 8'd1;
      emit(8'hA2, v, 2);
      emit(8'hA0, 16'h0000, 2);
      emit(8'hC8, 16'h0000, 1);
      emit(8'hCA, 16'h0000, 1);
      emit(8'hD0, 16'h00FC, 2);   // back to the iny
      emit(8'h84, 16'h0050, 2);
      emit(8'h4C, 16'h0C00, 3);
      emit(8'h8D, 16'h0304, 3);   // only on a failed jump
      wp = 16'h0C00;
      emit(8'hA9, 16'h005A, 2);
      emit(8'h8D, 16'h0305, 3);
      emit(8'h4C, 16'h0C05, 3);
   endtask

   task automatic run_program(input int stall);
      int cycles;
      @(posedge clk);
      reset_n <= 1'b0;
      repeat (4) @(posedge clk);
      mem = image;
      exp_addr = model_addr;
      exp_data = model_data;
      first_reads.delete();
      halt_reads = 0;
      stall_pct <= stall;
      reset_n   <= 1'b1;
      cycles = 0;
      while (halt_reads < 2) begin
         @(posedge clk);
         cycles++;
         if (cycles > 40000) begin
            $display("timeout: the program never reached its final jump");
            abort_run();
         end
      end
      check(exp_addr.size(), 0, "stores still expected");
      check(first_reads[0], 16'hFFFC, "first vector read");
      check(first_reads[1], 16'hFFFD, "second vector read");
      check(first_reads[2], {image[16'hFFFD], image[16'hFFFC]}, "first opcode fetch");
   endtask

   always @(negedge clk) begin
      if (!reset_n) begin
         if (in_reset) check(bus.rd | bus.wr, 0, "bus request while in reset");
         in_reset = 1'b1;
         waiting  = 1'b0;
      end else begin
         in_reset = 1'b0;
         if (waiting) check(bus, held_bus, "bus request changed while stalled");
         waiting  = (bus.rd || bus.wr) && !ready;
         held_bus = bus;
         if (ready && bus.rd) begin
            if (first_reads.size() < 3) first_reads.push_back(bus.addr);
            if (bus.addr == halt_addr) halt_reads++;
         end
         if (ready && bus.wr) begin
            if (exp_addr.size() == 0) begin
               $display("store to %h at %0t ns that the model does not predict", bus.addr, $time);
               abort_run();
            end else begin
               check(bus.addr, exp_addr.pop_front(), "store address");
               check(bus.wr_data, exp_data.pop_front(), "store data");
            end
         end
      end
   end

   initial begin
      reset_n    = 1'b0;
      ready      = 1'b0;
      stall_pct  = 0;
      errors     = 0;
      waiting    = 1'b0;
      in_reset   = 1'b0;
      halt_reads = 0;
      build_program();
      halt_addr = run_model();
      run_program(0);
      run_program(50);   // same stream with heavy stalls
      build_program();
      halt_addr = run_model();
      run_program(30);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: source/m6502_core.sv
/*
 * m6502 core top
 * sequencer, decoder, ALU and register file on one byte bus
 */
module m6502_core import m6502_pkg::*; #(
   parameter addr_t RESET_VECTOR = RESET_VECTOR_DEFAULT
) (
   input  logic     clk,
   input  logic     reset_n,
   input  data_t    rd_data_i,
   input  logic     ready_i,
   output bus_req_t bus_o
);

   data_t      opcode;
   decoded_t   decoded;
   regs_t      regs;
   alu_req_t   alu_req;
   data_t      alu_result;
   flags_t     alu_flags;
   writeback_t wb;

   m6502_sequencer #(
      .RESET_VECTOR (RESET_VECTOR)
   ) u_sequencer (
      .clk          (clk),
      .reset_n      (reset_n),
      .ready_i      (ready_i),
      .rd_data_i    (rd_data_i),
      .decoded_i    (decoded),
      .regs_i       (regs),
      .alu_result_i (alu_result),
      .alu_flags_i  (alu_flags),
      .opcode_o     (opcode),
      .bus_o        (bus_o),
      .alu_req_o    (alu_req),
      .wb_o         (wb)
   );

   m6502_decode u_decode (
      .opcode_i  (opcode),
      .decoded_o (decoded)
   );

   m6502_alu u_alu (
      .req_i    (alu_req),
      .result_o (alu_result),
      .flags_o  (alu_flags)
   );

   m6502_regfile u_regfile (
      .clk     (clk),
      .reset_n (reset_n),
      .wb_i    (wb),
      .regs_o  (regs)
   );

endmodule

// File: source/m6502_sequencer.sv
/*
 * m6502 sequencer
 * reset vector, fetch, operands, memory access, branch and writeback
 */
module m6502_sequencer import m6502_pkg::*; #(
   parameter addr_t RESET_VECTOR = RESET_VECTOR_DEFAULT
) (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       ready_i,
   input  data_t      rd_data_i,
   input  decoded_t   decoded_i,
   input  regs_t      regs_i,
   input  data_t      alu_result_i,
   input  flags_t     alu_flags_i,
   output data_t      opcode_o,
   output bus_req_t   bus_o,
   output alu_req_t   alu_req_o,
   output writeback_t wb_o
);

   typedef enum logic [2:0] {
      VECTOR_LO, VECTOR_HI, FETCH, OPERAND_LO, OPERAND_HI, MEM, BRANCH, EXECUTE
   } state_e;

   state_e state_q;
   logic   started_q;   // keeps the bus idle through reset
   data_t  opcode_q;
   data_t  operand_q;   // immediate, offset or loaded byte
   addr_t  ea_q;        // data address, later jump target
   data_t  src_val;
   addr_t  next_pc;
   addr_t  offset;
   logic   xfer;
   logic   taken;
   logic   nz_upd;

   assign opcode_o = (state_q == FETCH) ? rd_data_i : opcode_q;
   assign offset   = {{8{operand_q[7]}}, operand_q};

   always_comb begin
      case (decoded_i.src)
         REG_A:   src_val = regs_i.a;
         REG_X:   src_val = regs_i.x;
         REG_Y:   src_val = regs_i.y;
         default: src_val = operand_q;   // memory operand
      endcase
      case (decoded_i.mode)
         MODE_IMPLIED: next_pc = regs_i.pc + 16'd1;
         MODE_ABS:     next_pc = regs_i.pc + 16'd3;
         default:      next_pc = regs_i.pc + 16'd2;
      endcase
      case (decoded_i.cond[2:1])
         2'b00:   taken = (regs_i.flags.n == decoded_i.cond[0]);
         2'b01:   taken = (regs_i.flags.v == decoded_i.cond[0]);
         2'b10:   taken = (regs_i.flags.c == decoded_i.cond[0]);
         default: taken = (regs_i.flags.z == decoded_i.cond[0]);
      endcase
   end

   always_comb begin
      bus_o = '0;
      case (state_q)
         VECTOR_LO: begin
            bus_o.addr = RESET_VECTOR;
            bus_o.rd   = started_q;
         end
         VECTOR_HI: begin
            bus_o.addr = RESET_VECTOR + 16'd1;
            bus_o.rd   = 1'b1;
         end
         FETCH, OPERAND_LO, OPERAND_HI: begin
            bus_o.addr = regs_i.pc + {14'd0, state_q == OPERAND_HI, state_q == OPERAND_LO};
            bus_o.rd   = 1'b1;
         end
         MEM: begin
            bus_o.addr    = ea_q;
            bus_o.wr_data = src_val;
            bus_o.rd      = ~decoded_i.store;
            bus_o.wr      = decoded_i.store;
         end
         default: ;
      endcase
   end

   assign xfer = ready_i & (bus_o.rd | bus_o.wr);

   always_comb begin
      alu_req_o.op       = decoded_i.alu_op;
      alu_req_o.a        = src_val;
      alu_req_o.b        = decoded_i.invert ? ~operand_q : operand_q;
      alu_req_o.carry_in = regs_i.flags.c;
   end

   always_comb begin
      wb_o   = '0;
      nz_upd = (decoded_i.dst != REG_NONE) || (decoded_i.alu_op == ALU_CMP);
      if (state_q == VECTOR_HI) begin
         wb_o.pc    = {rd_data_i, ea_q[7:0]};
         wb_o.pc_we = xfer;
      end else if (state_q == EXECUTE) begin
         wb_o.reg_sel     = decoded_i.dst;
         wb_o.value       = alu_result_i;
         wb_o.flags       = alu_flags_i;
         wb_o.flag_mask.n = nz_upd;
         wb_o.flag_mask.z = nz_upd;
         wb_o.flag_mask.v = (decoded_i.alu_op == ALU_ADC);
         wb_o.flag_mask.c = decoded_i.alu_op inside {ALU_ADC, ALU_CMP} ||
                            decoded_i.op inside {OP_CLC, OP_SEC};
         if (decoded_i.op inside {OP_CLC, OP_SEC}) begin
            wb_o.flags.c = (decoded_i.op == OP_SEC);
         end
         wb_o.pc    = (decoded_i.op inside {OP_BRANCH, OP_JMP}) ? ea_q : next_pc;
         wb_o.pc_we = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state_q   <= VECTOR_LO;
         started_q <= 1'b0;
      end else begin
         started_q <= 1'b1;
         case (state_q)
            VECTOR_LO:  if (xfer) state_q <= VECTOR_HI;
            VECTOR_HI:  if (xfer) state_q <= FETCH;
            FETCH:      if (xfer) state_q <= (decoded_i.mode == MODE_IMPLIED) ? EXECUTE : OPERAND_LO;
            OPERAND_LO: if (xfer) begin
               case (decoded_i.mode)
                  MODE_ZP:  state_q <= MEM;
                  MODE_ABS: state_q <= OPERAND_HI;
                  MODE_REL: state_q <= BRANCH;
                  default:  state_q <= EXECUTE;
               endcase
            end
            OPERAND_HI: if (xfer) state_q <= (decoded_i.op == OP_JMP) ? EXECUTE : MEM;
            MEM:        if (xfer) state_q <= EXECUTE;
            BRANCH:     state_q <= EXECUTE;
            default:    state_q <= FETCH;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (xfer) begin
         case (state_q)
            VECTOR_LO:  ea_q[7:0] <= rd_data_i;
            FETCH:      opcode_q <= rd_data_i;
            OPERAND_LO: begin
               operand_q <= rd_data_i;
               ea_q      <= {8'h00, rd_data_i};   // zero page
            end
            OPERAND_HI: ea_q[15:8] <= rd_data_i;
            MEM:        if (!decoded_i.store) operand_q <= rd_data_i;
            default: ;
         endcase
      end
      if (state_q == BRANCH) begin
         ea_q <= taken ? next_pc + offset : next_pc;
      end
   end

endmodule

// File: source/m6502_regfile.sv
/*
 * m6502 register file
 * A, X, Y, PC and NVZC flags, written from the sequencer writeback
 */
module m6502_regfile import m6502_pkg::*; (
   input  logic       clk,
   input  logic       reset_n,
   input  writeback_t wb_i,
   output regs_t      regs_o
);

   regs_t  regs_q;
   flags_t flags_next;

   // keep flags outside the mask
   assign flags_next = (regs_q.flags & ~wb_i.flag_mask) | (wb_i.flags & wb_i.flag_mask);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         regs_q <= '0;
      end else begin
         case (wb_i.reg_sel)
            REG_A:   regs_q.a <= wb_i.value;
            REG_X:   regs_q.x <= wb_i.value;
            REG_Y:   regs_q.y <= wb_i.value;
            default: ;
         endcase
         regs_q.flags <= flags_next;
         if (wb_i.pc_we) begin
            regs_q.pc <= wb_i.pc;
         end
      end
   end

   assign regs_o = regs_q;

endmodule

// File: source/m6502_alu.sv
/*
 * m6502 ALU
 * combinational 8-bit logic, binary add, compare and inc/dec
 */
module m6502_alu import m6502_pkg::*; (
   input  alu_req_t req_i,
   output data_t    result_o,
   output flags_t   flags_o
);

   logic [8:0] sum;
   logic [8:0] diff;
   data_t      r;
   logic       c;
   logic       v;

   assign sum  = {1'b0, req_i.a} + {1'b0, req_i.b} + {8'h00, req_i.carry_in};
   assign diff = {1'b0, req_i.a} - {1'b0, req_i.b};

   always_comb begin
      c = req_i.carry_in;   // unchanged unless add or compare
      v = 1'b0;
      case (req_i.op)
         ALU_OR:  r = req_i.a | req_i.b;
         ALU_AND: r = req_i.a & req_i.b;
         ALU_EOR: r = req_i.a ^ req_i.b;
         ALU_ADC: begin
            r = sum[7:0];
            c = sum[8];
            // same sign in, other sign out
            v = ~(req_i.a[7] ^ req_i.b[7]) & (req_i.a[7] ^ sum[7]);
         end
         ALU_CMP: begin
            r = diff[7:0];
            c = ~diff[8];   // no borrow, a >= b
         end
         ALU_INC: r = req_i.a + 8'd1;
         ALU_DEC: r = req_i.a - 8'd1;
         default: r = req_i.a;
      endcase
   end

   assign result_o  = r;
   assign flags_o.n = r[7];
   assign flags_o.v = v;
   assign flags_o.z = (r == 8'h00);
   assign flags_o.c = c;

endmodule

// File: decode/m6502_decode.sv
/*
 * m6502 opcode decoder
 * aaabbbcc groups to operation, addressing mode, ALU function and registers
 */
module m6502_decode import m6502_pkg::*; (
   input  data_t    opcode_i,
   output decoded_t decoded_o
);

   logic [2:0] aaa;
   logic [2:0] bbb;
   logic [1:0] cc;
   decoded_t   d;
   addr_mode_e mode;

   assign aaa = opcode_i[7:5];
   assign bbb = opcode_i[4:2];
   assign cc  = opcode_i[1:0];

   // zp and abs columns are common, imm column depends on group
   function automatic addr_mode_e column_mode(input logic [2:0] col, input logic [2:0] imm_col);
      addr_mode_e m;
      case (col)
         3'b001:  m = MODE_ZP;
         3'b011:  m = MODE_ABS;
         default: m = (col == imm_col) ? MODE_IMM : MODE_IMPLIED;
      endcase
      return m;
   endfunction

   function automatic decoded_t make_dec(input cpu_op_e op, input alu_op_e alu,
                                         input reg_sel_e src, input reg_sel_e dst);
      decoded_t r;
      r        = '0;
      r.op     = op;
      r.alu_op = alu;
      r.src    = src;
      r.dst    = dst;
      r.store  = op inside {OP_STA, OP_STX, OP_STY};
      r.invert = (op == OP_SBC);
      return r;
   endfunction

   always_comb begin
      d    = '0;
      mode = MODE_IMPLIED;
      case (cc)
         2'b01: begin
            mode = column_mode(bbb, 3'b010);
            case (aaa)
               3'b000:  d = make_dec(OP_ORA, ALU_OR, REG_A, REG_A);
               3'b001:  d = make_dec(OP_AND, ALU_AND, REG_A, REG_A);
               3'b010:  d = make_dec(OP_EOR, ALU_EOR, REG_A, REG_A);
               3'b011:  d = make_dec(OP_ADC, ALU_ADC, REG_A, REG_A);
               3'b100:  d = make_dec(OP_STA, ALU_PASS, REG_A, REG_NONE);
               3'b101:  d = make_dec(OP_LDA, ALU_PASS, REG_NONE, REG_A);
               3'b110:  d = make_dec(OP_CMP, ALU_CMP, REG_A, REG_NONE);
               default: d = make_dec(OP_SBC, ALU_ADC, REG_A, REG_A);
            endcase
         end
         2'b10: begin
            mode = column_mode(bbb, 3'b000);
            case (aaa)
               3'b100:  d = make_dec(OP_STX, ALU_PASS, REG_X, REG_NONE);
               3'b101:  d = make_dec(OP_LDX, ALU_PASS, REG_NONE, REG_X);
               default: d = '0;   // shifts, inc/dec memory
            endcase
         end
         2'b00: begin
            mode = (bbb == 3'b100) ? MODE_REL : column_mode(bbb, 3'b000);
            case (aaa)
               3'b010:  d = make_dec(OP_JMP, ALU_PASS, REG_NONE, REG_NONE);
               3'b100:  d = make_dec(OP_STY, ALU_PASS, REG_Y, REG_NONE);
               3'b101:  d = make_dec(OP_LDY, ALU_PASS, REG_NONE, REG_Y);
               3'b110:  d = make_dec(OP_CPY, ALU_CMP, REG_Y, REG_NONE);
               3'b111:  d = make_dec(OP_CPX, ALU_CMP, REG_X, REG_NONE);
               default: d = '0;
            endcase
            if (bbb == 3'b100) begin
               d = make_dec(OP_BRANCH, ALU_PASS, REG_NONE, REG_NONE); // all eight
            end
         end
         default: ;
      endcase

      // columns the kept set does not cover fall back to a one byte nop
      if (d.op == OP_NOP || mode == MODE_IMPLIED ||
          (d.store && mode == MODE_IMM) ||
          (d.op == OP_JMP && mode != MODE_ABS) ||
          (d.op inside {OP_CPX, OP_CPY} && mode != MODE_IMM)) begin
         d    = '0;
         mode = MODE_IMPLIED;
      end
      d.mode = mode;

      case (opcode_i)
         8'h18:   d = make_dec(OP_CLC, ALU_PASS, REG_NONE, REG_NONE);
         8'h38:   d = make_dec(OP_SEC, ALU_PASS, REG_NONE, REG_NONE);
         8'h8A:   d = make_dec(OP_TXA, ALU_PASS, REG_X, REG_A);
         8'h98:   d = make_dec(OP_TYA, ALU_PASS, REG_Y, REG_A);
         8'hAA:   d = make_dec(OP_TAX, ALU_PASS, REG_A, REG_X);
         8'hA8:   d = make_dec(OP_TAY, ALU_PASS, REG_A, REG_Y);
         8'hE8:   d = make_dec(OP_INX, ALU_INC, REG_X, REG_X);
         8'hC8:   d = make_dec(OP_INY, ALU_INC, REG_Y, REG_Y);
         8'hCA:   d = make_dec(OP_DEX, ALU_DEC, REG_X, REG_X);
         8'h88:   d = make_dec(OP_DEY, ALU_DEC, REG_Y, REG_Y);
         default: ;
      endcase
      d.cond = aaa;
   end

   assign decoded_o = d;

endmodule

// File: common/m6502_pkg.sv
/*
 * m6502 shared types
 * bus request, decoded instruction, register file and writeback records
 */
package m6502_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   localparam addr_t RESET_VECTOR_DEFAULT = 16'hFFFC;

   typedef struct packed {
      logic n;
      logic v;
      logic z;
      logic c;
   } flags_t;

   // first member of each enum is the all-zero idle value
   typedef enum logic [5:0] {
      OP_NOP,
      OP_LDA, OP_LDX, OP_LDY,
      OP_STA, OP_STX, OP_STY,
      OP_ORA, OP_AND, OP_EOR, OP_ADC, OP_SBC,
      OP_CMP, OP_CPX, OP_CPY,
      OP_TAX, OP_TAY, OP_TXA, OP_TYA,
      OP_INX, OP_INY, OP_DEX, OP_DEY,
      OP_CLC, OP_SEC,
      OP_BRANCH, OP_JMP
   } cpu_op_e;

   typedef enum logic [2:0] {
      MODE_IMPLIED, MODE_IMM, MODE_ZP, MODE_ABS, MODE_REL
   } addr_mode_e;

   typedef enum logic [2:0] {
      ALU_PASS, ALU_OR, ALU_AND, ALU_EOR, ALU_ADC, ALU_CMP, ALU_INC, ALU_DEC
   } alu_op_e;

   typedef enum logic [1:0] {
      REG_NONE, REG_A, REG_X, REG_Y
   } reg_sel_e;

   typedef struct packed {
      cpu_op_e    op;
      addr_mode_e mode;
      alu_op_e    alu_op;
      reg_sel_e   src;
      reg_sel_e   dst;
      logic       store;
      logic       invert;   // sbc adds the complement
      logic [2:0] cond;     // aaa field of a branch
   } decoded_t;

   typedef struct packed {
      data_t  a;
      data_t  x;
      data_t  y;
      addr_t  pc;
      flags_t flags;
   } regs_t;

   typedef struct packed {
      alu_op_e op;
      data_t   a;
      data_t   b;
      logic    carry_in;
   } alu_req_t;

   typedef struct packed {
      reg_sel_e reg_sel;
      data_t    value;
      flags_t   flags;
      flags_t   flag_mask;
      addr_t    pc;
      logic     pc_we;
   } writeback_t;

   typedef struct packed {
      addr_t addr;
      data_t wr_data;
      logic  rd;
      logic  wr;
   } bus_req_t;

endpackage
